//--- verilog.f
+incdir+.
cpu_pkg.sv
ControlCore.sv
StageRegister.sv
BarrelShifter.sv
Alu.sv
RegisterBank.sv
ExecuteCore.sv
ExecuteCore_checker.sv
tb_ExecuteCore.sv

//--- run_sim.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_ExecuteCore -f verilog.f \
        > build.log 2>&1 \
        && ./obj_dir/Vtb_ExecuteCore > sim.log 2>&1 \
        || { cat build.log; echo "TESTBENCH FAILED" >> sim.log; }
cat sim.log
! grep -q "TESTBENCH FAILED" sim.log

//--- tb_ExecuteCore.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module tb_ExecuteCore;

        localparam int PERIOD = 8;

        logic                clock;
        logic                reset;
        logic                cmdValid;
        logic                cmdReady;
        cpu_pkg::execCmdT    cmd;
        logic                resValid;
        logic                resReady;
        cpu_pkg::execResultT res;

        int    seed      = 88;
        int    checks    = 0;
        int    errors    = 0;
        int    timeouts  = 0;
        bit    stallMode = 1'b0;
        string testName  = "reset";

        logic [`DATA_WIDTH-1:0] mRegs [`REG_COUNT];   // model register file
        logic [3:0]             mFlags;
        cpu_pkg::execResultT    expQ[$];
        longint                 timeQ[$];   // acceptance time per command

        int arithIds[$] = '{4, 5, 6, 7, 9, 18, 21, 34, 65};
        int shiftIds[$] = '{1, 2, 3, 14, 15, 16, 19};
        int logicIds[$] = '{12, 17, 24, 25, 26, 59, 60, 61, 62};
        int chainIds[$] = '{4, 5, 12, 21, 26, 56};
        int mixIds[$]   = '{1, 4, 5, 7, 9, 12, 15, 18, 19, 21, 25, 34, 56, 60, 65, 67};

        ExecuteCore i_dut (
                .clock    (clock),
                .reset    (reset),
                .cmdValid (cmdValid),
                .cmdReady (cmdReady),
                .cmd      (cmd),
                .resValid (resValid),
                .resReady (resReady),
                .res      (res)
        );

        bind ExecuteCore ExecuteCore_checker i_checker (
                .clock    (clock),
                .reset    (reset),
                .cmdReady (cmdReady),
                .resValid (resValid),
                .resReady (resReady),
                .res      (res),
                .halted   (halted)
        );

        initial begin
                clock = 1'b0;
                forever #(PERIOD / 2) clock = ~clock;
        end

        initial begin
                resReady = 1'b1;
                forever begin
                        @(negedge clock);
                        resReady = stallMode ? ($random(seed) % 4 != 0) : 1'b1;   // 1 in 4 stalls
                end
        end

        task automatic compareValue(input string what, input logic [63:0] expected,
                                    input logic [63:0] actual);
                checks++;
                if (expected !== actual) begin
                        errors++;
                        $display("** Error %s %s: expected %0h, actual %0h", testName, what,
                                 expected, actual);
                end
        endtask

        task automatic finishRun();
                $display("checks %0d, mismatches %0d, timeouts %0d, assertion failures %0d",
                         checks, errors, timeouts, i_dut.i_checker.failCount);
                if (errors == 0 && timeouts == 0 && i_dut.i_checker.failCount == 0) begin
                        $display("TESTBENCH PASSED");
                end else begin
                        $display("TESTBENCH FAILED");
                end
                $finish;
        endtask

        // instruction set rules applied to the model state
        function automatic cpu_pkg::execResultT refExecute(input cpu_pkg::execCmdT c);
                logic [31:0] a, b, y;
                logic [4:0]  amt;
                logic [3:0]  f;
                logic        cy, ov, wr;
                int          id;
                id  = int'(c.id);
                a   = mRegs[c.rn];
                b   = (id inside {[1:3], [6:11], 56, 57}) ? c.offset : mRegs[c.rm];
                amt = b[4:0];
                f   = mFlags;
                y   = b;
                cy  = f[1];
                ov  = f[0];
                if (id inside {[1:3], [14:16], 19}) begin
                        y = a;
                        if (amt != 0) begin
                                case (id)
                                        1, 14:   y = a >> amt;
                                        2, 15:   y = $signed(a) >>> amt;
                                        3, 16:   y = a << amt;
                                        default: y = (a >> amt) | (a << (32 - amt));
                                endcase
                                if (id == 3 || id == 16) begin
                                        cy = a[32 - amt];   // last bit out on the left
                                end else begin
                                        cy = (id == 19) ? y[31] : a[amt - 1];
                                end
                        end
                        f = {y[31], y == 0, cy, f[0]};
                end else begin
                        case (id)
                                4, 6, 56, 65, 21: begin
                                        {cy, y} = {1'b0, a} + {1'b0, b} + {32'd0, id == 21 && f[1]};
                                        ov      = (a[31] == b[31]) && (y[31] != a[31]);
                                end
                                5, 7, 9, 34: begin
                                        y  = a - b;
                                        cy = a >= b;   // carry means no borrow
                                        ov = (a[31] != b[31]) && (y[31] != a[31]);
                                end
                                18: begin
                                        y  = b - a;
                                        cy = b >= a;
                                        ov = (a[31] != b[31]) && (y[31] != b[31]);
                                end
                                12: y = a ^ b;
                                17: y = a & b;
                                24: y = a & ~b;
                                25: y = ~b;
                                26: y = a | b;
                                59: y = {{24{b[7]}}, b[7:0]};
                                60: y = {{16{b[15]}}, b[15:0]};
                                61: y = {24'd0, b[7:0]};
                                62: y = {16'd0, b[15:0]};
                                default: y = b;   // dropped rows and halt
                        endcase
                        if (id inside {4, 5, 6, 7, 9, 18, 21, 34, 65}) begin
                                f = {y[31], y == 0, cy, ov};
                        end else if (id inside {12, 17, 24, 25, 26}) begin
                                f = {y[31], y == 0, f[1:0]};
                        end
                end
                wr = !(id inside {9, 34, 65, 67, 75});
                if (wr) begin
                        mRegs[c.rd] = y;
                end
                mFlags = f;
                return '{rd: c.rd, wrote: wr, value: y, flags: f};
        endfunction

        function automatic cpu_pkg::execCmdT randomCmd(input int id);
                cpu_pkg::execCmdT c;
                c.id     = id[`ID_WIDTH-1:0];
                c.rd     = 3'($random(seed));
                c.rn     = 3'($random(seed));
                c.rm     = 3'($random(seed));
                c.offset = $random(seed);
                return c;
        endfunction

        task automatic sendCmd(input cpu_pkg::execCmdT c);
                int waited;
                @(negedge clock);
                cmd      = c;
                cmdValid = 1'b1;
                waited   = 0;
                @(posedge clock);
                while (!cmdReady && waited < 100) begin
                        waited++;
                        @(posedge clock);
                end
                if (!cmdReady) begin
                        timeouts++;
                        $display("timeout: command id %0d never accepted in %s", c.id, testName);
                        finishRun();
                end else begin
                        expQ.push_back(refExecute(c));
                        timeQ.push_back($time);
                end
        endtask

        task automatic drain();
                int waited;
                @(negedge clock);
                cmdValid = 1'b0;
                waited   = 0;
                while (expQ.size() != 0 && waited < 200) begin
                        @(negedge clock);
                        waited++;
                end
                if (expQ.size() != 0) begin
                        timeouts++;
                        $display("timeout: %0d results never came out in %s", expQ.size(), testName);
                        finishRun();
                end
        endtask

        task automatic runOps(input int ids[$], input int count);
                for (int n = 0; n < count; n++) begin
                        sendCmd(randomCmd(ids[$unsigned($random(seed)) % ids.size()]));
                end
                drain();
        endtask

        // compares every output transfer in order
        initial begin
                cpu_pkg::execResultT expRes;
                longint tIn;
                longint now;
                longint lastLow;
                lastLow = -100;
                forever begin
                        @(posedge clock);
                        now = $time;
                        if (!reset && resValid && resReady) begin
                                if (expQ.size() == 0) begin
                                        errors++;
                                        $display("result came out with no command pending in %s",
                                                 testName);
                                end else begin
                                        expRes = expQ.pop_front();
                                        tIn    = timeQ.pop_front();
                                        compareValue("rd", expRes.rd, res.rd);
                                        compareValue("wrote", expRes.wrote, res.wrote);
                                        compareValue("value", expRes.value, res.value);
                                        compareValue("flags", expRes.flags, res.flags);
                                        if (lastLow < tIn + PERIOD) begin   // ready held high
                                                compareValue("latency", 2, (now - tIn) / PERIOD);
                                        end
                                end
                        end
                        if (!resReady) begin
                                lastLow = now;
                        end
                end
        end

        initial begin
                cpu_pkg::execCmdT c;
                int prevRd;
                cmdValid = 1'b0;
                cmd      = '0;
                reset    = 1'b1;
                mFlags   = '0;
                for (int i = 0; i < `REG_COUNT; i++) begin
                        mRegs[i] = '0;
                end
                repeat (3) @(posedge clock);
                @(negedge clock);
                reset = 1'b0;

                testName = "load";
                for (int i = 0; i < `REG_COUNT; i++) begin
                        c    = randomCmd(56);
                        c.rd = 3'(i);
                        c.rn = 3'(i);
                        sendCmd(c);
                end
                drain();

                testName = "arith";
                runOps(arithIds, 40);

                testName = "shift";
                for (int i = 1; i <= 3; i++) begin
                        c        = randomCmd(i);
                        c.offset = 32'd0;
                        sendCmd(c);
                        c.offset = 32'd31;
                        sendCmd(c);
                end
                runOps(shiftIds, 40);

                testName = "logic";
                runOps(logicIds, 40);

                testName = "chain";
                prevRd   = 0;
                for (int n = 0; n < 12; n++) begin
                        c      = randomCmd(chainIds[$unsigned($random(seed)) % chainIds.size()]);
                        c.rn   = 3'(prevRd);
                        prevRd = int'(c.rd);
                        sendCmd(c);
                end
                drain();

                // stall mode only changes away from the falling edge
                testName  = "backpressure";
                @(posedge clock);
                stallMode = 1'b1;
                runOps(mixIds, 200);
                @(posedge clock);
                stallMode = 1'b0;

                testName = "halt";
                sendCmd(randomCmd(67));
                sendCmd(randomCmd(75));
                drain();
                @(negedge clock);
                cmd      = randomCmd(4);
                cmdValid = 1'b1;
                repeat (5) begin
                        @(posedge clock);
                        compareValue("cmdReady", 0, cmdReady);
                end
                @(negedge clock);
                cmdValid = 1'b0;
                repeat (4) @(posedge clock);
                finishRun();
        end

endmodule

//--- ExecuteCore_checker.sv
`timescale 1ns/1ps

module ExecuteCore_checker (
        input logic                clock,
        input logic                reset,
        input logic                cmdReady,
        input logic                resValid,
        input logic                resReady,
        input cpu_pkg::execResultT res,
        input logic                halted
);

        int failCount = 0;

        // stalled result holds still
        resHeld: assert property (@(posedge clock) disable iff (reset)
                resValid && !resReady |=> resValid && $stable(res))
        else begin
                failCount++;
                $error("result changed or vanished while stalled");
        end

        // halt is sticky and keeps the input closed
        haltClosed: assert property (@(posedge clock) disable iff (reset)
                halted |=> halted && !cmdReady)
        else begin
                failCount++;
                $error("halt state lost or cmdReady high after halt");
        end

        resetClear: assert property (@(posedge clock) reset |=> !resValid)
        else begin
                failCount++;
                $error("resValid high right after reset");
        end

endmodule

//--- ExecuteCore.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module ExecuteCore (
        input  logic                 clock,
        input  logic                 reset,
        input  logic                 cmdValid,
        output logic                 cmdReady,
        input  cpu_pkg::execCmdT     cmd,
        output logic                 resValid,
        input  logic                 resReady,
        output cpu_pkg::execResultT  res
);

        cpu_pkg::execCmdT       curCmd;
        cpu_pkg::ctrlWordT      ctrl;
        cpu_pkg::execResultT    result;
        logic [`DATA_WIDTH-1:0] readA, readB, aluValue;
        logic [3:0]             flags, aluFlags;
        logic                   aluWrite, halted, stop;
        logic                   s1InReady, s1Valid, s2InReady, advance;

        // a halt in stage 1 already closes the input
        assign stop     = halted || (s1Valid && !ctrl.enable);
        assign cmdReady = s1InReady && !stop;
        assign advance  = s1Valid && s2InReady;

        assign result = '{rd: curCmd.rd, wrote: aluWrite, value: aluValue, flags: aluFlags};

        StageRegister #(.payloadT(cpu_pkg::execCmdT)) i_cmdStage (
                .clock    (clock),
                .reset    (reset),
                .inValid  (cmdValid && !stop),
                .inReady  (s1InReady),
                .inData   (cmd),
                .outValid (s1Valid),
                .outReady (s2InReady),
                .outData  (curCmd)
        );

        ControlCore i_control (
                .id   (curCmd.id),
                .ctrl (ctrl)
        );

        RegisterBank i_regs (
                .clock     (clock),
                .reset     (reset),
                .rn        (curCmd.rn),
                .rm        (curCmd.rm),
                .advance   (advance),
                .writeEn   (aluWrite),
                .rd        (curCmd.rd),
                .writeData (aluValue),
                .flagsIn   (aluFlags),
                .haltIn    (!ctrl.enable),
                .readA     (readA),
                .readB     (readB),
                .flags     (flags),
                .halted    (halted)
        );

        Alu i_alu (
                .ctrl     (ctrl),
                .regA     (readA),
                .regB     (readB),
                .offset   (curCmd.offset),
                .flagsIn  (flags),
                .value    (aluValue),
                .flagsOut (aluFlags),
                .write    (aluWrite)
        );

        StageRegister #(.payloadT(cpu_pkg::execResultT)) i_resStage (
                .clock    (clock),
                .reset    (reset),
                .inValid  (s1Valid),
                .inReady  (s2InReady),
                .inData   (result),
                .outValid (resValid),
                .outReady (resReady),
                .outData  (res)
        );

endmodule

//--- RegisterBank.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module RegisterBank (
        input  logic                       clock,
        input  logic                       reset,
        input  logic [`REG_ADDR_WIDTH-1:0] rn,
        input  logic [`REG_ADDR_WIDTH-1:0] rm,
        input  logic                       advance,   // stage 1 moves on
        input  logic                       writeEn,
        input  logic [`REG_ADDR_WIDTH-1:0] rd,
        input  logic [`DATA_WIDTH-1:0]     writeData,
        input  logic [3:0]                 flagsIn,
        input  logic                       haltIn,
        output logic [`DATA_WIDTH-1:0]     readA,
        output logic [`DATA_WIDTH-1:0]     readB,
        output logic [3:0]                 flags,
        output logic                       halted
);

        logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

        assign readA = regs[rn];
        assign readB = regs[rm];

        always_ff @(posedge clock) begin
                if (reset) begin
                        for (int i = 0; i < `REG_COUNT; i++) begin
                                regs[i] <= '0;
                        end
                        flags  <= 4'b0000;
                        halted <= 1'b0;
                end else if (advance) begin
                        if (writeEn) begin
                                regs[rd] <= writeData;
                        end
                        flags  <= flagsIn;
                        halted <= halted || haltIn;   // sticky until reset
                end
        end

endmodule

//--- Alu.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module Alu (
        input  cpu_pkg::ctrlWordT      ctrl,
        input  logic [`DATA_WIDTH-1:0] regA,
        input  logic [`DATA_WIDTH-1:0] regB,
        input  logic [`DATA_WIDTH-1:0] offset,
        input  logic [3:0]             flagsIn,
        output logic [`DATA_WIDTH-1:0] value,
        output logic [3:0]             flagsOut,
        output logic                   write
);

        localparam int W = `DATA_WIDTH;

        logic [W-1:0] rawB, chanB, shiftY, aluY, opX, opY;
        logic [W:0]   sum;
        logic         shiftCarry, addCin, isArith, isShift, overflow, neg, zero;

        assign rawB = ctrl.useOffset ? offset : regB;

        always_comb begin
                case (ctrl.extendOp)
                        cpu_pkg::extSignByte: chanB = {{(W-8){rawB[7]}}, rawB[7:0]};
                        cpu_pkg::extSignHalf: chanB = {{(W-16){rawB[15]}}, rawB[15:0]};
                        cpu_pkg::extZeroByte: chanB = {{(W-8){1'b0}}, rawB[7:0]};
                        cpu_pkg::extZeroHalf: chanB = {{(W-16){1'b0}}, rawB[15:0]};
                        default:              chanB = rawB;
                endcase
        end

        BarrelShifter i_shifter (
                .a        (regA),
                .amount   (chanB[4:0]),
                .op       (ctrl.shiftOp),
                .carryIn  (flagsIn[1]),
                .y        (shiftY),
                .carryOut (shiftCarry)
        );

        // one adder with operands steered per op
        always_comb begin
                opX     = regA;
                opY     = chanB;
                addCin  = 1'b0;
                isArith = 1'b1;
                case (ctrl.aluOp)
                        cpu_pkg::aluAdd, cpu_pkg::aluCmn: addCin = 1'b0;
                        cpu_pkg::aluSub, cpu_pkg::aluCmp: begin
                                opY    = ~chanB;
                                addCin = 1'b1;
                        end
                        cpu_pkg::aluAdc: addCin = flagsIn[1];
                        cpu_pkg::aluRsb: begin
                                opX    = chanB;
                                opY    = ~regA;
                                addCin = 1'b1;
                        end
                        default: isArith = 1'b0;
                endcase
        end

        assign sum      = {1'b0, opX} + {1'b0, opY} + {{W{1'b0}}, addCin};
        assign overflow = (opX[W-1] == opY[W-1]) && (sum[W-1] != opX[W-1]);

        always_comb begin
                case (ctrl.aluOp)
                        cpu_pkg::aluPassA: aluY = regA;
                        cpu_pkg::aluAnd:   aluY = regA & chanB;
                        cpu_pkg::aluEor:   aluY = regA ^ chanB;
                        cpu_pkg::aluOrr:   aluY = regA | chanB;
                        cpu_pkg::aluBic:   aluY = regA & ~chanB;
                        cpu_pkg::aluMvn:   aluY = ~chanB;
                        default:           aluY = isArith ? sum[W-1:0] : chanB;
                endcase
        end

        assign isShift = ctrl.shiftOp inside {cpu_pkg::shiftLsl, cpu_pkg::shiftLsr,
                                              cpu_pkg::shiftAsr, cpu_pkg::shiftRor};
        assign value = isShift ? shiftY : aluY;
        assign neg   = value[W-1];
        assign zero  = (value == '0);

        always_comb begin
                case (ctrl.flagMode)
                        cpu_pkg::flagShift: flagsOut = {neg, zero, shiftCarry, flagsIn[0]};
                        cpu_pkg::flagArith, cpu_pkg::flagCompare: begin
                                flagsOut = isArith ? {neg, zero, sum[W], overflow}
                                                   : {neg, zero, flagsIn[1:0]};
                        end
                        cpu_pkg::flagLogic: flagsOut = {neg, zero, flagsIn[1:0]};
                        default:            flagsOut = flagsIn;   // none and halt
                endcase
        end

        // compares only touch the flags
        assign write = ctrl.writeRd && ctrl.enable
                       && (ctrl.flagMode != cpu_pkg::flagCompare)
                       && !(ctrl.aluOp inside {cpu_pkg::aluCmp, cpu_pkg::aluCmn});

endmodule

//--- BarrelShifter.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module BarrelShifter (
        input  logic [`DATA_WIDTH-1:0] a,
        input  logic [4:0]             amount,
        input  cpu_pkg::shiftOpT       op,
        input  logic                   carryIn,
        output logic [`DATA_WIDTH-1:0] y,
        output logic                   carryOut
);

        logic [2*`DATA_WIDTH-1:0] rotated;

        assign rotated = {a, a} >> amount;

        // extra bit next to a catches the last bit shifted out
        always_comb begin
                y        = a;
                carryOut = carryIn;
                if (amount != 5'd0) begin
                        case (op)
                                cpu_pkg::shiftLsl: {carryOut, y} = {1'b0, a} << amount;
                                cpu_pkg::shiftLsr: {y, carryOut} = {a, 1'b0} >> amount;
                                cpu_pkg::shiftAsr: begin
                                        {y, carryOut} = $signed({a, 1'b0}) >>> amount;
                                end
                                cpu_pkg::shiftRor: begin
                                        y        = rotated[`DATA_WIDTH-1:0];
                                        carryOut = rotated[`DATA_WIDTH-1];
                                end
                                default: y = a;
                        endcase
                end
        end

endmodule

//--- StageRegister.sv
`timescale 1ns/1ps

module StageRegister #(
        parameter type payloadT = logic
) (
        input  logic    clock,
        input  logic    reset,
        input  logic    inValid,
        output logic    inReady,
        input  payloadT inData,
        output logic    outValid,
        input  logic    outReady,
        output payloadT outData
);

        // room when empty or when the held entry leaves this cycle
        assign inReady = !outValid || outReady;

        always_ff @(posedge clock) begin
                if (reset) begin
                        outValid <= 1'b0;
                end else if (inReady) begin
                        outValid <= inValid;
                end
        end

        always_ff @(posedge clock) begin
                if (inReady && inValid) begin
                        outData <= inData;
                end
        end

endmodule

//--- ControlCore.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module ControlCore (
        input  logic [`ID_WIDTH-1:0] id,
        output cpu_pkg::ctrlWordT    ctrl
);

        always_comb begin
                ctrl.aluOp     = cpu_pkg::aluPassB;
                ctrl.shiftOp   = cpu_pkg::shiftNone;
                ctrl.extendOp  = cpu_pkg::extNone;
                ctrl.flagMode  = cpu_pkg::flagNone;
                ctrl.writeRd   = 1'b1;
                ctrl.useOffset = 1'b0;
                ctrl.enable    = 1'b1;

                case (id) inside
                        4, 6, 10, 23, [28:30], 56, 57: ctrl.aluOp = cpu_pkg::aluAdd;
                        5, 7, 9, 11, 22, [31:33]: ctrl.aluOp = cpu_pkg::aluSub;
                        12: ctrl.aluOp = cpu_pkg::aluEor;
                        13: ctrl.aluOp = cpu_pkg::aluOpT'(4'd13);   // passes b in this core
                        17: ctrl.aluOp = cpu_pkg::aluAnd;
                        18: ctrl.aluOp = cpu_pkg::aluRsb;
                        20: ctrl.aluOp = cpu_pkg::aluOpT'(4'd14);   // passes b as well
                        21: ctrl.aluOp = cpu_pkg::aluAdc;
                        24: ctrl.aluOp = cpu_pkg::aluBic;
                        25: ctrl.aluOp = cpu_pkg::aluMvn;
                        26: ctrl.aluOp = cpu_pkg::aluOrr;
                        34: ctrl.aluOp = cpu_pkg::aluCmp;
                        65: ctrl.aluOp = cpu_pkg::aluCmn;
                endcase

                // immediate and register forms share the shift codes
                case (id) inside
                        1, 14: ctrl.shiftOp = cpu_pkg::shiftLsr;
                        2, 15: ctrl.shiftOp = cpu_pkg::shiftAsr;
                        3, 16: ctrl.shiftOp = cpu_pkg::shiftLsl;
                        19: ctrl.shiftOp = cpu_pkg::shiftRor;
                        63: ctrl.shiftOp = cpu_pkg::shiftOpT'(4'd6);   // no shift here
                        64: ctrl.shiftOp = cpu_pkg::shiftOpT'(4'd7);
                        66: ctrl.shiftOp = cpu_pkg::shiftOpT'(4'd8);
                endcase

                case (id) inside
                        59: ctrl.extendOp = cpu_pkg::extSignByte;
                        60: ctrl.extendOp = cpu_pkg::extSignHalf;
                        61: ctrl.extendOp = cpu_pkg::extZeroByte;
                        62: ctrl.extendOp = cpu_pkg::extZeroHalf;
                endcase

                ctrl.useOffset = id inside {[1:3], [6:11], 56, 57};

                case (id) inside
                        [1:3], [14:16], 19: ctrl.flagMode = cpu_pkg::flagShift;
                        [4:7], [9:11], 17, 18, [21:23], [31:33]: begin
                                ctrl.flagMode = cpu_pkg::flagArith;
                        end
                        8, 12, 13, 20, [24:27]: ctrl.flagMode = cpu_pkg::flagLogic;
                        34, 65: ctrl.flagMode = cpu_pkg::flagCompare;
                        75: begin
                                ctrl.flagMode = cpu_pkg::flagHalt;
                                ctrl.enable   = 1'b0;
                        end
                endcase

                // first match wins
                case (id) inside
                        9, 22, 23, 30, 32, 33, 75: ctrl.writeRd = 1'b0;   // flags only, or halt
                        [1:34], [56:66]: ;
                        default: ctrl.writeRd = 1'b0;   // memory, i/o, branch, unknown
                endcase
        end

endmodule

//--- cpu_pkg.sv
`include "cpu_settings.svh"

package cpu_pkg;

        typedef struct packed {
                logic [`ID_WIDTH-1:0]       id;
                logic [`REG_ADDR_WIDTH-1:0] rd;
                logic [`REG_ADDR_WIDTH-1:0] rn;
                logic [`REG_ADDR_WIDTH-1:0] rm;
                logic [`DATA_WIDTH-1:0]     offset;
        } execCmdT;

        // codes 12 and up all pass channel B
        typedef enum logic [3:0] {
                aluPassA = 4'd0,
                aluAnd   = 4'd1,
                aluAdd   = 4'd2,
                aluEor   = 4'd3,
                aluOrr   = 4'd4,
                aluSub   = 4'd5,
                aluAdc   = 4'd6,
                aluBic   = 4'd7,
                aluRsb   = 4'd8,   // b minus a
                aluMvn   = 4'd9,
                aluCmp   = 4'd10,
                aluCmn   = 4'd11,
                aluPassB = 4'd12
        } aluOpT;

        typedef enum logic [3:0] {
                shiftNone = 4'd0,
                shiftLsl  = 4'd2,
                shiftLsr  = 4'd3,
                shiftAsr  = 4'd4,
                shiftRor  = 4'd5
        } shiftOpT;

        typedef enum logic [2:0] {
                extNone     = 3'd0,
                extSignByte = 3'd1,
                extSignHalf = 3'd2,
                extZeroByte = 3'd3,
                extZeroHalf = 3'd4
        } extendOpT;

        typedef enum logic [2:0] {
                flagNone    = 3'd0,
                flagShift   = 3'd1,   // nzc
                flagArith   = 3'd2,   // nzcv
                flagLogic   = 3'd3,   // nz
                flagCompare = 3'd4,   // nzcv without a register write
                flagHalt    = 3'd6
        } flagModeT;

        typedef struct packed {
                aluOpT    aluOp;
                shiftOpT  shiftOp;
                extendOpT extendOp;
                flagModeT flagMode;
                logic     writeRd;
                logic     useOffset;
                logic     enable;
        } ctrlWordT;

        typedef struct packed {
                logic [`REG_ADDR_WIDTH-1:0] rd;
                logic                       wrote;
                logic [`DATA_WIDTH-1:0]     value;
                logic [3:0]                 flags;   // n z c v
        } execResultT;

endpackage

//--- cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// data path width
`define DATA_WIDTH 32

// general registers r0..r7
`define REG_COUNT 8

// register number width
`define REG_ADDR_WIDTH 3

// operation id width
`define ID_WIDTH 7

`endif
